//--- logic/div_defines.svh
`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

`default_nettype none

// Datapath widths
`define DIV_XLEN      64  // Operand and result width
`define DIV_WLEN      32  // Word form width
`define DIV_TAG_W     5   // Destination tag

// Radix-4 iteration, two quotient bits retired per cycle
`define DIV_STEP_BITS 2

// Counter load values, one extra count so done reads at 1
`define DIV_ITER_64   33
`define DIV_ITER_32   17
`define DIV_CNT_W     6

`default_nettype wire

`endif

//--- logic/div_op_pkg.sv
`include "div_defines.svh"

`default_nettype none

package div_op_pkg;

    typedef logic [`DIV_XLEN-1:0]  div_data_t;
    typedef logic [`DIV_TAG_W-1:0] div_tag_t;

    // Operation kind, word forms selected by is_word
    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_kind_e;

    typedef struct packed {
        logic      valid;
        div_kind_e kind;
        logic      is_word;  // DIVW, DIVUW, REMW, REMUW
        div_tag_t  tag;
        div_data_t rs1;      // Dividend
        div_data_t rs2;      // Divisor
    } div_req_t;

    typedef struct packed {
        logic      valid;    // High for one cycle
        div_tag_t  tag;
        div_data_t result;
    } div_res_t;

endpackage

`default_nettype wire

//--- logic/div_lane_pkg.sv
`include "div_defines.svh"

`default_nettype none

package div_lane_pkg;

    // Everything the input side prepares for one lane
    typedef struct packed {
        logic                  busy;
        div_op_pkg::div_tag_t  tag;
        logic                  is_word;
        logic                  signed_op;
        logic                  is_rem;
        logic                  div_zero;
        logic                  same_sign;          // Operand signs agree
        div_op_pkg::div_data_t dividend_raw;       // Kept for div-by-zero and remainder sign
        div_op_pkg::div_data_t remainder;
        div_op_pkg::div_data_t dividend_quotient;  // Dividend out at top, quotient in at bottom
        div_op_pkg::div_data_t divisor;
    } lane_load_t;

    typedef struct packed {
        logic [`DIV_CNT_W-1:0] cnt;  // Remaining iterations plus one
        lane_load_t            op;
    } lane_state_t;

endpackage

`default_nettype wire

//--- logic/div_operand_prep.sv
`include "div_defines.svh"

`default_nettype none

module div_operand_prep (
    input  div_op_pkg::div_req_t     req_i,
    input  logic                     lane_sel_i,
    output div_lane_pkg::lane_load_t load_o,
    output logic [1:0]               load_en_o
);

    import div_op_pkg::*;
    import div_lane_pkg::*;

    logic      signed_op;
    logic      rs1_sign;
    logic      rs2_sign;
    logic      rs1_neg;
    logic      rs2_neg;
    div_data_t rs1_mag;
    div_data_t rs2_mag;

    // ------------------------------------------------------------
    // Operand signs and magnitudes
    // ------------------------------------------------------------
    assign signed_op = (req_i.kind == DIV) || (req_i.kind == REM);

    // Sign bit sits at 31 for word forms
    assign rs1_sign = req_i.is_word ? req_i.rs1[`DIV_WLEN-1] : req_i.rs1[`DIV_XLEN-1];
    assign rs2_sign = req_i.is_word ? req_i.rs2[`DIV_WLEN-1] : req_i.rs2[`DIV_XLEN-1];

    assign rs1_neg = signed_op & rs1_sign;
    assign rs2_neg = signed_op & rs2_sign;

    // Low word of the negation is the negation of the low word
    assign rs1_mag = rs1_neg ? -req_i.rs1 : req_i.rs1;
    assign rs2_mag = rs2_neg ? -req_i.rs2 : req_i.rs2;

    // ------------------------------------------------------------
    // Lane load record
    // ------------------------------------------------------------
    always_comb begin
        load_o.busy      = 1'b1;
        load_o.tag       = req_i.tag;
        load_o.is_word   = req_i.is_word;
        load_o.signed_op = signed_op;
        load_o.is_rem    = (req_i.kind == REM) || (req_i.kind == REMU);
        load_o.div_zero  = req_i.is_word ? (req_i.rs2[`DIV_WLEN-1:0] == '0)
                                         : (req_i.rs2 == '0);
        load_o.same_sign    = ~(rs1_sign ^ rs2_sign);
        load_o.dividend_raw = req_i.rs1;
        load_o.remainder    = '0;

        if (req_i.is_word) begin
            // Word dividend goes on top so it shifts out first
            load_o.dividend_quotient = {rs1_mag[`DIV_WLEN-1:0], {(`DIV_XLEN-`DIV_WLEN){1'b0}}};
            load_o.divisor           = {{(`DIV_XLEN-`DIV_WLEN){1'b0}}, rs2_mag[`DIV_WLEN-1:0]};
        end else begin
            load_o.dividend_quotient = rs1_mag;
            load_o.divisor           = rs2_mag;
        end
    end

    assign load_en_o = {req_i.valid & lane_sel_i, req_i.valid & ~lane_sel_i};

endmodule

`default_nettype wire

//--- logic/div_lane.sv
`include "div_defines.svh"

`default_nettype none

module div_lane (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      flush_i,
    input  logic                      load_en_i,
    input  div_lane_pkg::lane_load_t  load_i,
    output div_lane_pkg::lane_state_t state_o,
    output logic                      done_o
);

    import div_op_pkg::*;
    import div_lane_pkg::*;

    lane_state_t        state_q;
    div_data_t          rem_step;
    div_data_t          dq_step;
    logic [`DIV_XLEN:0] shifted;  // One bit wider, partial remainder may reach 2*divisor
    logic [`DIV_XLEN:0] trial;

    // ------------------------------------------------------------
    // Restoring step, unrolled per cycle
    // ------------------------------------------------------------
    always_comb begin
        rem_step = state_q.op.remainder;
        dq_step  = state_q.op.dividend_quotient;
        shifted  = '0;
        trial    = '0;
        for (int s = 0; s < `DIV_STEP_BITS; s++) begin
            shifted = {rem_step, dq_step[`DIV_XLEN-1]};
            trial   = shifted - {1'b0, state_q.op.divisor};
            // Top bit of trial set means the subtraction underflowed
            if (!trial[`DIV_XLEN]) begin
                rem_step = trial[`DIV_XLEN-1:0];
            end else begin
                rem_step = shifted[`DIV_XLEN-1:0];
            end
            dq_step = {dq_step[`DIV_XLEN-2:0], ~trial[`DIV_XLEN]};
        end
    end

    // ------------------------------------------------------------
    // Lane registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q.cnt     <= '0;
            state_q.op.busy <= 1'b0;
        end else if (flush_i) begin
            // Flush beats a load in the same cycle
            state_q.cnt     <= '0;
            state_q.op.busy <= 1'b0;
        end else if (load_en_i) begin
            state_q.op  <= load_i;
            state_q.cnt <= load_i.is_word ? `DIV_CNT_W'(`DIV_ITER_32)
                                          : `DIV_CNT_W'(`DIV_ITER_64);
        end else if (state_q.cnt != '0) begin
            state_q.op.remainder         <= rem_step;
            state_q.op.dividend_quotient <= dq_step;
            state_q.cnt                  <= state_q.cnt - `DIV_CNT_W'(1);
            if (state_q.cnt == `DIV_CNT_W'(1)) begin
                state_q.op.busy <= 1'b0;  // Result leaves this cycle
            end
        end
    end

    assign state_o = state_q;
    assign done_o  = (state_q.cnt == `DIV_CNT_W'(1));

endmodule

`default_nettype wire

//--- logic/div_result_fixup.sv
`include "div_defines.svh"

`default_nettype none

module div_result_fixup (
    input  div_lane_pkg::lane_state_t state0_i,
    input  div_lane_pkg::lane_state_t state1_i,
    input  logic [1:0]                done_i,
    output div_op_pkg::div_res_t      res_o
);

    import div_op_pkg::*;
    import div_lane_pkg::*;

    lane_load_t sel;
    logic       dividend_neg;
    div_data_t  quo;
    div_data_t  rmd;
    div_data_t  pick;

    // Lane 0 has priority when both finish together
    assign sel = done_i[0] ? state0_i.op : state1_i.op;

    assign dividend_neg = sel.signed_op &
                          (sel.is_word ? sel.dividend_raw[`DIV_WLEN-1]
                                       : sel.dividend_raw[`DIV_XLEN-1]);

    // ------------------------------------------------------------
    // Sign restore and special cases
    // ------------------------------------------------------------
    always_comb begin
        if (sel.div_zero) begin
            quo = '1;
        end else if (sel.signed_op && !sel.same_sign) begin
            quo = -sel.dividend_quotient;
        end else begin
            quo = sel.dividend_quotient;
        end
    end

    always_comb begin
        if (sel.div_zero) begin
            rmd = sel.dividend_raw;  // Remainder is the dividend itself
        end else if (dividend_neg) begin
            rmd = -sel.remainder;    // Takes the dividend's sign
        end else begin
            rmd = sel.remainder;
        end
    end

    assign pick = sel.is_rem ? rmd : quo;

    // ------------------------------------------------------------
    // Result
    // ------------------------------------------------------------
    always_comb begin
        res_o.valid = |done_i;
        res_o.tag   = sel.tag;
        if (sel.is_word) begin
            res_o.result = {{(`DIV_XLEN-`DIV_WLEN){pick[`DIV_WLEN-1]}}, pick[`DIV_WLEN-1:0]};
        end else begin
            res_o.result = pick;
        end
    end

endmodule

`default_nettype wire

//--- logic/div_unit.sv
`default_nettype none

module div_unit (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 flush_i,     // Kills both lanes
    input  logic                 lane_sel_i,  // Lane that takes the request
    input  div_op_pkg::div_req_t req_i,
    output div_op_pkg::div_res_t res_o
);

    import div_lane_pkg::*;

    lane_load_t  load;
    logic [1:0]  load_en;
    lane_state_t state0;
    lane_state_t state1;
    logic [1:0]  done;

    div_operand_prep prep (
        .req_i      (req_i),
        .lane_sel_i (lane_sel_i),
        .load_o     (load),
        .load_en_o  (load_en)
    );

    div_lane lane0 (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .flush_i   (flush_i),
        .load_en_i (load_en[0]),
        .load_i    (load),
        .state_o   (state0),
        .done_o    (done[0])
    );

    div_lane lane1 (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .flush_i   (flush_i),
        .load_en_i (load_en[1]),
        .load_i    (load),
        .state_o   (state1),
        .done_o    (done[1])
    );

    div_result_fixup fixup (
        .state0_i (state0),
        .state1_i (state1),
        .done_i   (done),
        .res_o    (res_o)
    );

endmodule

`default_nettype wire

//--- dv/div_unit_asserts.sv
`default_nettype none

module div_unit_asserts (
    input logic                 clk_i,
    input logic                 rstn_i,
    input logic                 flush_i,
    input logic [1:0]           load_en_i,
    input logic [1:0]           busy_i,
    input logic [1:0]           done_i,
    input div_op_pkg::div_res_t res_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // A result is sampled 17 or 33 edges after the edge that loaded its lane
    res_after_load: assert property (@(posedge clk_i) disable iff (!rstn_i)
        res_i.valid |->
            ($past(load_en_i != 2'b00, 17) || $past(load_en_i != 2'b00, 33)))
        else $error("result valid without a lane load 16 or 32 cycles earlier");

    // Lane 1 would be lost if both finished together
    lanes_apart: assert property (@(posedge clk_i) disable iff (!rstn_i)
        done_i != 2'b11)
        else $error("both lanes done in the same cycle");

    // Flush empties both lanes at once
    flush_quiet: assert property (@(posedge clk_i) disable iff (!rstn_i)
        flush_i |=> (busy_i == 2'b00) && !res_i.valid)
        else $error("lane busy or result valid in the cycle after a flush");

endmodule

`default_nettype wire

//--- dv/div_unit_checker.sv
`include "div_defines.svh"

`default_nettype none

module div_unit_checker (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  div_op_pkg::div_req_t req_i,
    input  div_op_pkg::div_res_t res_i,
    input  logic                 end_check_i,
    output logic                 check_done_o,
    output int                   mismatch_cnt_o,
    output int                   other_cnt_o
);

    timeunit 1ns;
    timeprecision 1ps;

    import div_op_pkg::*;

    localparam int MAX_ROWS = 32;
    localparam int COLS     = 8;
    localparam int N_TAGS   = 1 << `DIV_TAG_W;

    logic [63:0] stim [MAX_ROWS*COLS];
    div_data_t   exp_result [N_TAGS];
    int          exp_lat    [N_TAGS];
    logic        listed     [N_TAGS];
    logic        killed     [N_TAGS];  // Flushed before it can finish
    logic        issued     [N_TAGS];
    logic        returned   [N_TAGS];
    int          issue_cyc  [N_TAGS];
    int          cyc;

    // ------------------------------------------------------------
    // Expected results by tag
    // ------------------------------------------------------------
    initial begin
        div_tag_t tag;

        for (int i = 0; i < MAX_ROWS*COLS; i++) begin
            stim[i] = 64'hE0D0_0000_0000_0000 | 64'(i);
        end
        for (int t = 0; t < N_TAGS; t++) begin
            listed[t]     = 1'b0;
            killed[t]     = 1'b0;
            exp_lat[t]    = 0;
            exp_result[t] = '0;
        end
        $readmemh("dv/div_unit_stimulus.txt", stim);
        for (int r = 0; r < MAX_ROWS && stim[r*COLS] <= 64'd1; r++) begin
            tag             = div_tag_t'(stim[r*COLS+4]);
            listed[tag]     = 1'b1;
            killed[tag]     = stim[r*COLS][0];
            exp_lat[tag]    = stim[r*COLS+3][0] ? 16 : 32;  // Word forms need half the steps
            exp_result[tag] = stim[r*COLS+7];
        end
    end

    task automatic check_result(input div_res_t res);
        int seen;

        seen = cyc - issue_cyc[res.tag] - 1;  // Issue edge to the edge after done
        if (!listed[res.tag] || !issued[res.tag]) begin
            $display("Result with tag %0d arrived but no such request was issued", res.tag);
            other_cnt_o++;
        end else if (returned[res.tag]) begin
            $display("Result with tag %0d arrived a second time", res.tag);
            other_cnt_o++;
        end else if (killed[res.tag]) begin
            $display("Flushed operation with tag %0d still returned a result", res.tag);
            returned[res.tag] = 1'b1;
            other_cnt_o++;
        end else begin
            returned[res.tag] = 1'b1;
            if (res.result !== exp_result[res.tag]) begin
                $display("Error: res_o.result tag %0d got 0x%h expected 0x%h",
                         res.tag, res.result, exp_result[res.tag]);
                mismatch_cnt_o++;
            end
            if (seen != exp_lat[res.tag]) begin
                $display("Result with tag %0d came %0d cycles after issue instead of %0d",
                         res.tag, seen, exp_lat[res.tag]);
                other_cnt_o++;
            end
        end
    endtask

    task automatic final_check();
        for (int t = 0; t < N_TAGS; t++) begin
            if (listed[t] && !issued[t]) begin
                $display("Tag %0d from the stimulus file was never issued", t);
                other_cnt_o++;
            end else if (listed[t] && !killed[t] && !returned[t]) begin
                $display("Tag %0d was issued but its result never came back", t);
                other_cnt_o++;
            end
        end
    endtask

    // ------------------------------------------------------------
    // Monitor
    // ------------------------------------------------------------
    always @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cyc            = 0;
            mismatch_cnt_o = 0;
            other_cnt_o    = 0;
            check_done_o   = 1'b0;
            for (int t = 0; t < N_TAGS; t++) begin
                issued[t]    = 1'b0;
                returned[t]  = 1'b0;
                issue_cyc[t] = 0;
            end
        end else begin
            cyc++;
            if (req_i.valid) begin
                issued[req_i.tag]    = 1'b1;
                issue_cyc[req_i.tag] = cyc;
            end
            if (res_i.valid) begin
                check_result(res_i);
            end
            if (end_check_i && !check_done_o) begin
                final_check();
                check_done_o = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/div_unit_tb.sv
`default_nettype none

module div_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import div_op_pkg::*;

    localparam int MAX_ROWS = 32;
    localparam int COLS     = 8;  // ctl lane kind word tag rs1 rs2 expected

    logic        clk_i = 1'b0;
    logic        rstn_i;
    logic        flush_i;
    logic        lane_sel_i;
    div_req_t    req_i;
    div_res_t    res_o;

    logic [63:0] stim [MAX_ROWS*COLS];
    int          n_rows;
    logic        rows_loaded;
    logic        end_check;
    logic        check_done;
    int          mismatches;
    int          other_errors;
    logic [31:0] lfsr;

    // Scheduler view of the lanes in drive edges
    int          now;
    int          free_at [2];
    int          fin_at  [2];
    logic        killed  [2];

    always #2 clk_i = ~clk_i;

    div_unit dut (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .flush_i    (flush_i),
        .lane_sel_i (lane_sel_i),
        .req_i      (req_i),
        .res_o      (res_o)
    );

    div_unit_checker scoreboard (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .req_i          (req_i),
        .res_i          (res_o),
        .end_check_i    (end_check),
        .check_done_o   (check_done),
        .mismatch_cnt_o (mismatches),
        .other_cnt_o    (other_errors)
    );

    bind div_unit div_unit_asserts asrt (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .flush_i   (flush_i),
        .load_en_i (load_en),
        .busy_i    ({state1.op.busy, state0.op.busy}),
        .done_i    (done),
        .res_i     (res_o)
    );

    // Galois taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_gap(output int gap);
        logic [2:0] bits;

        for (int b = 0; b < 3; b++) begin
            bits[b] = lfsr[0];
            lfsr    = lfsr_next(lfsr);
        end
        gap = int'(bits) + 1;  // 1 to 8 idle cycles
    endtask

    task automatic idle_cycle();
        @(posedge clk_i);
        now++;
        req_i.valid <= 1'b0;
        flush_i     <= 1'b0;
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin : drive
        int   base;
        int   gap;
        int   lat;
        logic lane;
        logic kill;

        rstn_i      = 1'b0;
        flush_i     = 1'b0;
        lane_sel_i  = 1'b0;
        req_i       = '0;
        end_check   = 1'b0;
        rows_loaded = 1'b0;
        lfsr        = 32'hb6f;
        now         = 0;
        free_at     = '{0, 0};
        fin_at      = '{-1, -1};
        killed      = '{1'b0, 1'b0};

        for (int i = 0; i < MAX_ROWS*COLS; i++) begin
            stim[i] = 64'hE0D0_0000_0000_0000 | 64'(i);  // Never a valid ctl value
        end
        $readmemh("dv/div_unit_stimulus.txt", stim);
        n_rows = 0;
        while (n_rows < MAX_ROWS && stim[n_rows*COLS] <= 64'd1) begin
            n_rows++;
        end
        rows_loaded = 1'b1;

        repeat (16) @(posedge clk_i);
        rstn_i <= 1'b1;

        for (int r = 0; r < n_rows; r++) begin
            base = r * COLS;
            kill = stim[base][0];
            lane = stim[base+1][0];
            lat  = stim[base+3][0] ? 16 : 32;
            draw_gap(gap);
            repeat (gap + 1) idle_cycle();  // First edge ends the previous request
            // Stretch until the lane is idle and the finish cycles differ
            while (now < free_at[lane] || now + lat == fin_at[!lane] ||
                   (kill && !killed[!lane] && now < free_at[!lane])) begin
                idle_cycle();
            end
            lane_sel_i      <= lane;
            req_i.valid     <= 1'b1;
            req_i.kind      <= div_kind_e'(stim[base+2][1:0]);
            req_i.is_word   <= stim[base+3][0];
            req_i.tag       <= div_tag_t'(stim[base+4]);
            req_i.rs1       <= stim[base+5];
            req_i.rs2       <= stim[base+6];
            free_at[lane] = now + lat + 1;
            fin_at[lane]  = now + lat;
            killed[lane]  = kill;
            if (kill && killed[!lane]) begin
                // Both lanes busy with doomed ops
                idle_cycle();
                flush_i <= 1'b1;
                idle_cycle();
                free_at = '{now, now};
                fin_at  = '{-1, -1};
                killed  = '{1'b0, 1'b0};
            end
        end

        while (now < free_at[0] + 2 || now < free_at[1] + 2) begin
            idle_cycle();
        end
        end_check <= 1'b1;
        wait (check_done);
        $display("Errors: %0d value mismatches, %0d other failures, 0 timeouts",
                 mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (rows_loaded);
        repeat ((n_rows + 4) * 48) @(posedge clk_i);
        $display("Run timed out after %0d cycles before all results were checked",
                 (n_rows + 4) * 48);
        $display("Errors: %0d value mismatches, %0d other failures, 1 timeouts",
                 mismatches, other_errors);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- div_unit.f
+incdir+logic
logic/div_op_pkg.sv
logic/div_lane_pkg.sv
logic/div_operand_prep.sv
logic/div_lane.sv
logic/div_result_fixup.sv
logic/div_unit.sv
dv/div_unit_asserts.sv
dv/div_unit_checker.sv
dv/div_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the divider testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module div_unit_tb -f div_unit.f -o div_unit_sim

./obj_dir/div_unit_sim 2>&1 | tee sim.log

if grep -q "test failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished without a reported failure"

//--- dv/div_unit_stimulus.txt
// ctl(1 = flushed) lane kind(0 DIV 1 DIVU 2 REM 3 REMU) word tag rs1 rs2 expected
// All values hex, one operation per line
0 0 0 0 00 FFFFFFFFFFFFFF9C 0000000000000007 FFFFFFFFFFFFFFF2
0 1 2 0 01 FFFFFFFFFFFFFF9C 0000000000000007 FFFFFFFFFFFFFFFE
0 0 0 0 02 0000000000000064 FFFFFFFFFFFFFFF9 FFFFFFFFFFFFFFF2
0 1 2 0 03 0000000000000064 FFFFFFFFFFFFFFF9 0000000000000002
0 0 1 0 04 FFFFFFFFFFFFFF9C 0000000000000010 0FFFFFFFFFFFFFF9
0 1 3 0 05 FFFFFFFFFFFFFF9C 0000000000000010 000000000000000C
0 0 0 0 06 FFFFFFFFFFFFF000 FFFFFFFFFFFFFFF0 0000000000000100
0 1 0 1 07 AAAAAAAAFFFFFF9C 5555555500000007 FFFFFFFFFFFFFFF2
0 0 3 1 08 1234567880000005 FFFFFFFF00000010 0000000000000005
0 1 1 1 09 77777777FFFFFFF0 ABCD000000000001 FFFFFFFFFFFFFFF0
0 0 2 1 0a DEADBEEFFFFFFFF9 0000000000000002 FFFFFFFFFFFFFFFF
0 1 0 0 0b 0000000000001234 0000000000000000 FFFFFFFFFFFFFFFF
0 0 3 0 0c 8000000000000123 0000000000000000 8000000000000123
0 1 0 1 0d 0000000000000005 FFFFFFFF00000000 FFFFFFFFFFFFFFFF
0 0 2 1 0e 1111111180000000 2222222200000000 FFFFFFFF80000000
0 1 0 0 0f 8000000000000000 FFFFFFFFFFFFFFFF 8000000000000000
0 0 2 0 10 8000000000000000 FFFFFFFFFFFFFFFF 0000000000000000
0 1 0 1 11 0000000080000000 00000000FFFFFFFF FFFFFFFF80000000
1 0 1 0 12 0000000000000064 0000000000000007 000000000000000E
1 1 2 1 13 0000000000000064 0000000000000007 0000000000000002
0 0 0 0 14 7FFFFFFFFFFFFFFF 0000000000000002 3FFFFFFFFFFFFFFF
0 1 3 0 15 7FFFFFFFFFFFFFFF 0000000000000010 000000000000000F
